/* logic/fpu_exc_pkg.sv */
// Shared definitions for the fp32 exception unit
// Word layouts follow the x87 control and status words, the stack fields are not modelled
package fpu_exc_pkg;

    // ========================================
    // Exception vector bit positions
    // ========================================
    localparam int exc_invalid   = 0;
    localparam int exc_denormal  = 1;
    localparam int exc_zero_div  = 2;
    localparam int exc_overflow  = 3;
    localparam int exc_underflow = 4;
    localparam int exc_precision = 5;
    localparam int num_exc       = 6;

    // Host commands
    typedef enum logic [1:0] {
        cmd_op   = 2'd0,
        cmd_ldcw = 2'd1,
        cmd_stsw = 2'd2,
        cmd_clex = 2'd3
    } cmd_t;

    // Operations checked before execution
    typedef enum logic [1:0] {
        op_add = 2'd0,
        op_sub = 2'd1,
        op_mul = 2'd2,
        op_div = 2'd3
    } op_t;

    // Control word, raw host view or decoded fields
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [3:0]         reserved_hi;
            logic [1:0]         rounding_ctl;
            logic [1:0]         precision_ctl;
            logic [1:0]         reserved_lo;
            logic [num_exc-1:0] masks;
        } f;
    } control_word_u;

    // Status word, raw host view or decoded fields
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic               busy;
            logic [6:0]         unused;
            logic               error_summary;
            logic               stack_fault;
            logic [num_exc-1:0] flags;
        } f;
    } status_word_u;

    // x87 power-up default, all exceptions masked
    localparam logic [15:0] cw_reset_value = 16'h037F;

endpackage

/* logic/fpu_exception_handler.sv */
// Sticky exception latch for the six x87 exception classes
// Clear takes priority over latch when both are requested
`timescale 1ns/1ps

module fpu_exception_handler (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [fpu_exc_pkg::num_exc-1:0] exception_flags,
    input  logic [fpu_exc_pkg::num_exc-1:0] masks,
    input  logic                          exception_latch,
    input  logic                          exception_clear,
    output logic [fpu_exc_pkg::num_exc-1:0] latched_exceptions,
    output logic                          int_request,
    output logic                          has_unmasked_exception
);

    // ========================================
    // Incoming flag qualification
    // ========================================

    // Flags that would trap with the masks as they are right now
    logic [fpu_exc_pkg::num_exc-1:0] new_unmasked;
    logic                            raise_int;

    assign new_unmasked = exception_flags & ~masks;
    assign raise_int    = |new_unmasked;

    // ========================================
    // Sticky latches and interrupt request
    // ========================================

    always_ff @(posedge clk) begin
        if (reset || exception_clear) begin
            // Clear also wins over a simultaneous latch
            latched_exceptions <= '0;
            int_request        <= 1'b0;
        end else if (exception_latch) begin
            // OR in, never drop a flag already seen
            latched_exceptions <= latched_exceptions | exception_flags;
            // Interrupt only from flags arriving now, not from a later unmask
            if (raise_int) begin
                int_request <= 1'b1;
            end
        end
    end

    // ========================================
    // Live summary against current masks
    // ========================================

    // Follows mask changes immediately, feeds ES in the status word
    assign has_unmasked_exception = |(latched_exceptions & ~masks);

endmodule

/* logic/fpu_operand_check.sv */
// Pre-operation exception check on two fp32 operands
// Only invalid, denormal and zero-divide are detected here, no result is computed
`timescale 1ns/1ps

module fpu_operand_check (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    check_start,
    input  fpu_exc_pkg::op_t        op,
    input  logic [31:0]             a,
    input  logic [31:0]             b,
    output logic [2:0]              pre_flags
);

    // ========================================
    // Operand field decode
    // ========================================

    logic a_exp_zero, a_exp_ones, a_man_zero;
    logic b_exp_zero, b_exp_ones, b_man_zero;

    assign a_exp_zero = (a[30:23] == 8'h00);
    assign a_exp_ones = &a[30:23];
    assign a_man_zero = (a[22:0] == 23'd0);
    assign b_exp_zero = (b[30:23] == 8'h00);
    assign b_exp_ones = &b[30:23];
    assign b_man_zero = (b[22:0] == 23'd0);

    // Operand classes, anything left over is a normal number
    logic a_zero, a_den, a_inf, a_qnan, a_snan;
    logic b_zero, b_den, b_inf, b_snan;

    assign a_zero = a_exp_zero & a_man_zero;
    assign a_den  = a_exp_zero & ~a_man_zero;
    assign a_inf  = a_exp_ones & a_man_zero;
    // Quiet NaN has the top mantissa bit set
    assign a_qnan = a_exp_ones & a[22];
    assign a_snan = a_exp_ones & ~a[22] & ~a_man_zero;

    assign b_zero = b_exp_zero & b_man_zero;
    assign b_den  = b_exp_zero & ~b_man_zero;
    assign b_inf  = b_exp_ones & b_man_zero;
    assign b_snan = b_exp_ones & ~b[22] & ~b_man_zero;

    // ========================================
    // Exception rules per operation
    // ========================================

    logic invalid_form;
    logic invalid_next, denormal_next, zero_div_next;

    always_comb begin
        case (op)
            // inf + (-inf)
            fpu_exc_pkg::op_add: invalid_form = a_inf & b_inf & (a[31] != b[31]);
            // inf - inf of the same sign
            fpu_exc_pkg::op_sub: invalid_form = a_inf & b_inf & (a[31] == b[31]);
            fpu_exc_pkg::op_mul: invalid_form = (a_zero & b_inf) | (a_inf & b_zero);
            default:             invalid_form = (a_zero & b_zero) | (a_inf & b_inf);
        endcase
    end

    assign invalid_next  = a_snan | b_snan | invalid_form;
    assign denormal_next = a_den | b_den;
    // Finite nonzero dividend over zero, quiet NaNs stay silent
    assign zero_div_next = (op == fpu_exc_pkg::op_div) & b_zero & ~a_zero & ~a_inf &
                           ~a_qnan & ~a_snan;

    // Held between checks so the latch strobe sees stable flags
    always_ff @(posedge clk) begin
        if (reset) begin
            pre_flags <= '0;
        end else if (check_start) begin
            pre_flags[fpu_exc_pkg::exc_invalid]  <= invalid_next;
            pre_flags[fpu_exc_pkg::exc_denormal] <= denormal_next;
            pre_flags[fpu_exc_pkg::exc_zero_div] <= zero_div_next;
        end
    end

endmodule

/* logic/fpu_host_port.sv */
// Four-phase req/ack command port, host fields must stay stable until ack is high
// A new request is ignored until the previous ack has dropped
`timescale 1ns/1ps

module fpu_host_port (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       host_req,
    input  fpu_exc_pkg::cmd_t          host_cmd,
    input  logic [15:0]                host_wdata,
    input  fpu_exc_pkg::status_word_u  status_word,
    output logic                       host_ack,
    output logic [15:0]                host_rdata,
    output logic                       check_start,
    output logic                       exception_latch,
    output logic                       exception_clear,
    output logic                       cw_load,
    output logic [15:0]                cw_wdata
);

    // ========================================
    // FSM encoding
    // ========================================

    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_execute = 2'd1;
    localparam logic [1:0] st_ack     = 2'd2;
    localparam logic [1:0] st_release = 2'd3;

    logic [1:0]        state;
    logic              accept;
    logic              in_execute;
    fpu_exc_pkg::cmd_t cmd_q;
    logic [15:0]       stsw_q;

    // Request taken on the first edge that sees req in idle
    assign accept     = (state == st_idle) && host_req;
    assign in_execute = (state == st_execute);

    // ========================================
    // Command strobes
    // ========================================

    // Operands are checked on the accepting edge itself
    assign check_start     = accept && (host_cmd == fpu_exc_pkg::cmd_op);
    // One cycle later the checked flags are latched
    assign exception_latch = in_execute && (cmd_q == fpu_exc_pkg::cmd_op);
    assign exception_clear = in_execute && (cmd_q == fpu_exc_pkg::cmd_clex);
    assign cw_load         = in_execute && (cmd_q == fpu_exc_pkg::cmd_ldcw);
    // Host keeps wdata stable through the whole transfer
    assign cw_wdata        = host_wdata;

    // ========================================
    // Sequencing
    // ========================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            host_ack   <= 1'b0;
            host_rdata <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (host_req) begin
                        state <= st_execute;
                    end
                end
                st_execute: begin
                    state <= st_ack;
                end
                st_ack: begin
                    // Read data appears together with ack
                    host_ack <= 1'b1;
                    if (cmd_q == fpu_exc_pkg::cmd_stsw) begin
                        host_rdata <= stsw_q;
                    end
                    state <= st_release;
                end
                default: begin
                    // Hold ack until the host lets go of req
                    if (!host_req) begin
                        host_ack   <= 1'b0;
                        host_rdata <= '0;
                        state      <= st_idle;
                    end
                end
            endcase
        end
    end

    // Command and status snapshot, only meaningful within a transfer
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_q <= host_cmd;
        end
        if (in_execute && (cmd_q == fpu_exc_pkg::cmd_stsw)) begin
            stsw_q <= status_word.raw;
        end
    end

endmodule

/* logic/fpu_control_status.sv */
// Control word register and status word assembly
// Precision and rounding control are stored only, they steer nothing here
`timescale 1ns/1ps

module fpu_control_status (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            cw_load,
    input  logic [15:0]                     cw_wdata,
    input  logic [fpu_exc_pkg::num_exc-1:0] latched_exceptions,
    input  logic                            has_unmasked_exception,
    output logic [fpu_exc_pkg::num_exc-1:0] masks,
    output fpu_exc_pkg::status_word_u       status_word
);

    // ========================================
    // Control word
    // ========================================

    fpu_exc_pkg::control_word_u control_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            // All exceptions masked out of reset
            control_word.raw <= fpu_exc_pkg::cw_reset_value;
        end else if (cw_load) begin
            control_word.raw <= cw_wdata;
        end
    end

    // Mask bits in exception order
    assign masks = control_word.f.masks;

    // ========================================
    // Status word
    // ========================================

    always_comb begin
        status_word.raw             = '0;
        status_word.f.flags         = latched_exceptions;
        // No register stack, so never a stack fault
        status_word.f.stack_fault   = 1'b0;
        status_word.f.error_summary = has_unmasked_exception;
        // B mirrors ES as on later x87 parts
        status_word.f.busy          = has_unmasked_exception;
    end

endmodule

/* logic/fpu_exception_unit.sv */
// Top level of the fp32 exception unit
// Overflow, underflow and precision come from an outside arithmetic core via the host
`timescale 1ns/1ps

module fpu_exception_unit (
    input  logic              clk,
    input  logic              reset,
    input  logic              host_req,
    input  fpu_exc_pkg::cmd_t host_cmd,
    input  fpu_exc_pkg::op_t  host_op,
    input  logic [31:0]       host_a,
    input  logic [31:0]       host_b,
    // Overflow in bit 0, underflow in bit 1, precision in bit 2
    input  logic [2:0]        host_post_flags,
    input  logic [15:0]       host_wdata,
    output logic              host_ack,
    output logic [15:0]       host_rdata,
    output logic              int_request
);

    // ========================================
    // Internal wiring
    // ========================================

    logic                            check_start;
    logic                            exception_latch;
    logic                            exception_clear;
    logic                            cw_load;
    logic [15:0]                     cw_wdata;
    logic [2:0]                      pre_flags;
    logic [fpu_exc_pkg::num_exc-1:0] exception_flags;
    logic [fpu_exc_pkg::num_exc-1:0] masks;
    logic [fpu_exc_pkg::num_exc-1:0] latched_exceptions;
    logic                            has_unmasked_exception;
    fpu_exc_pkg::status_word_u       status_word;

    // Pre-check flags in the low half, post-operation flags in the high half
    assign exception_flags[fpu_exc_pkg::exc_invalid]   = pre_flags[fpu_exc_pkg::exc_invalid];
    assign exception_flags[fpu_exc_pkg::exc_denormal]  = pre_flags[fpu_exc_pkg::exc_denormal];
    assign exception_flags[fpu_exc_pkg::exc_zero_div]  = pre_flags[fpu_exc_pkg::exc_zero_div];
    assign exception_flags[fpu_exc_pkg::exc_overflow]  = host_post_flags[0];
    assign exception_flags[fpu_exc_pkg::exc_underflow] = host_post_flags[1];
    assign exception_flags[fpu_exc_pkg::exc_precision] = host_post_flags[2];

    fpu_host_port i_host_port (
        .clk(clk), .reset(reset),
        .host_req(host_req), .host_cmd(host_cmd), .host_wdata(host_wdata),
        .status_word(status_word), .host_ack(host_ack), .host_rdata(host_rdata),
        .check_start(check_start), .exception_latch(exception_latch),
        .exception_clear(exception_clear), .cw_load(cw_load), .cw_wdata(cw_wdata)
    );

    fpu_operand_check i_operand_check (
        .clk(clk), .reset(reset), .check_start(check_start),
        .op(host_op), .a(host_a), .b(host_b), .pre_flags(pre_flags)
    );

    fpu_exception_handler i_exception_handler (
        .clk(clk), .reset(reset),
        .exception_flags(exception_flags), .masks(masks),
        .exception_latch(exception_latch), .exception_clear(exception_clear),
        .latched_exceptions(latched_exceptions), .int_request(int_request),
        .has_unmasked_exception(has_unmasked_exception)
    );

    fpu_control_status i_control_status (
        .clk(clk), .reset(reset), .cw_load(cw_load), .cw_wdata(cw_wdata),
        .latched_exceptions(latched_exceptions),
        .has_unmasked_exception(has_unmasked_exception),
        .masks(masks), .status_word(status_word)
    );

endmodule

/* tb/tb_fpu_exception_unit.sv */
// Random command testbench for the fp32 exception unit with a reference model
// Post-operation flags are random host inputs, the model follows the x87 word layout
`timescale 1ns/1ps

module tb_fpu_exception_unit;

    localparam int clk_period   = 8;
    localparam int num_random   = 400;
    localparam int num_directed = 40;
    localparam int cycle_limit  = 20;

    // Operand classes of the model
    localparam logic [2:0] cls_normal = 3'd0;
    localparam logic [2:0] cls_zero   = 3'd1;
    localparam logic [2:0] cls_den    = 3'd2;
    localparam logic [2:0] cls_inf    = 3'd3;
    localparam logic [2:0] cls_qnan   = 3'd4;
    localparam logic [2:0] cls_snan   = 3'd5;

    logic              clk = 1'b0;
    logic              reset;
    logic              host_req;
    fpu_exc_pkg::cmd_t host_cmd;
    fpu_exc_pkg::op_t  host_op;
    logic [31:0]       host_a;
    logic [31:0]       host_b;
    logic [2:0]        host_post_flags;
    logic [15:0]       host_wdata;
    logic              host_ack;
    logic [15:0]       host_rdata;
    logic              int_request;

    // Reference model state
    logic [15:0] model_cw;
    logic [5:0]  model_lat;
    logic        model_int;
    int          errors;
    int          commands;

    fpu_exception_unit i_dut (
        .clk(clk), .reset(reset),
        .host_req(host_req), .host_cmd(host_cmd), .host_op(host_op),
        .host_a(host_a), .host_b(host_b), .host_post_flags(host_post_flags),
        .host_wdata(host_wdata), .host_ack(host_ack), .host_rdata(host_rdata),
        .int_request(int_request)
    );

    always #(clk_period / 2) clk = ~clk;

    // ========================================
    // Model functions
    // ========================================

    function automatic logic [2:0] classify(input logic [31:0] x);
        if (x[30:23] == 8'h00) begin
            return (x[22:0] == 23'd0) ? cls_zero : cls_den;
        end
        if (x[30:23] != 8'hff) begin
            return cls_normal;
        end
        if (x[22:0] == 23'd0) begin
            return cls_inf;
        end
        return x[22] ? cls_qnan : cls_snan;
    endfunction

    // Bit 0 invalid, bit 1 denormal, bit 2 zero divide
    function automatic logic [2:0] expected_pre(input fpu_exc_pkg::op_t op,
                                                input logic [31:0] a, input logic [31:0] b);
        logic [2:0] ca;
        logic [2:0] cb;
        logic       inv;
        logic       zd;
        ca  = classify(a);
        cb  = classify(b);
        inv = (ca == cls_snan) || (cb == cls_snan);
        zd  = 1'b0;
        case (op)
            fpu_exc_pkg::op_add: inv |= (ca == cls_inf) && (cb == cls_inf) && (a[31] != b[31]);
            fpu_exc_pkg::op_sub: inv |= (ca == cls_inf) && (cb == cls_inf) && (a[31] == b[31]);
            fpu_exc_pkg::op_mul: inv |= ((ca == cls_zero) && (cb == cls_inf)) ||
                                        ((ca == cls_inf) && (cb == cls_zero));
            default: begin
                inv |= ((ca == cls_zero) && (cb == cls_zero)) ||
                       ((ca == cls_inf) && (cb == cls_inf));
                // Finite nonzero dividend only
                zd = (cb == cls_zero) && ((ca == cls_normal) || (ca == cls_den));
            end
        endcase
        return {zd, (ca == cls_den) || (cb == cls_den), inv};
    endfunction

    // Weighted operand pool, normals most often
    function automatic logic [31:0] random_operand();
        logic [22:0] man;
        logic        sign;
        sign = $urandom_range(0, 1);
        man  = $urandom;
        case ($urandom_range(0, 11))
            0, 1:    return {sign, 8'h00, 23'd0};
            2, 3:    return {sign, 8'hff, 23'd0};
            4:       return {sign, 8'hff, 1'b1, man[21:0]};
            5:       return {sign, 8'hff, 1'b0, man[21:1], 1'b1};
            6, 7:    return {sign, 8'h00, man[22:1], 1'b1};
            default: return {sign, 8'($urandom_range(1, 254)), man};
        endcase
    endfunction

    function automatic fpu_exc_pkg::op_t random_op();
        case ($urandom_range(0, 3))
            0:       return fpu_exc_pkg::op_add;
            1:       return fpu_exc_pkg::op_sub;
            2:       return fpu_exc_pkg::op_mul;
            default: return fpu_exc_pkg::op_div;
        endcase
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0t: %s", $time, msg);
        errors++;
    endtask

    // ========================================
    // Host transfer with checks
    // ========================================

    task automatic send_command(input fpu_exc_pkg::cmd_t cmd, input fpu_exc_pkg::op_t op,
                                input logic [31:0] a, input logic [31:0] b,
                                input logic [2:0] post, input logic [15:0] wdata);
        logic [5:0]  flags;
        logic [15:0] exp_rdata;
        logic        es;
        int          waited;
        exp_rdata = '0;
        // Model update ahead of the transfer, effects are visible with ack
        case (cmd)
            fpu_exc_pkg::cmd_op: begin
                flags = {post, expected_pre(op, a, b)};
                if (|(flags & ~model_cw[5:0])) begin
                    model_int = 1'b1;
                end
                model_lat = model_lat | flags;
            end
            fpu_exc_pkg::cmd_ldcw: model_cw = wdata;
            fpu_exc_pkg::cmd_stsw: begin
                es        = |(model_lat & ~model_cw[5:0]);
                // Busy mirrors ES
                exp_rdata = {es, 7'd0, es, 1'b0, model_lat};
            end
            default: begin
                model_lat = '0;
                model_int = 1'b0;
            end
        endcase
        commands++;
        @(posedge clk);
        host_req        <= 1'b1;
        host_cmd        <= cmd;
        host_op         <= op;
        host_a          <= a;
        host_b          <= b;
        host_post_flags <= post;
        host_wdata      <= wdata;
        waited = 0;
        while (!host_ack) begin
            @(negedge clk);
            waited++;
            if (!host_ack && (host_rdata != 16'd0)) begin
                report_mismatch($sformatf("rdata %h while ack low", host_rdata));
            end
        end
        // One negedge before the accepting edge, ack two edges after it
        if (waited != 4) begin
            report_mismatch($sformatf("ack seen after %0d half periods, expected 4", waited));
        end
        if (host_rdata != exp_rdata) begin
            report_mismatch($sformatf("cmd %0d rdata %h, expected %h", cmd, host_rdata,
                                      exp_rdata));
        end
        if (int_request != model_int) begin
            report_mismatch($sformatf("cmd %0d int_request %b, expected %b", cmd,
                                      int_request, model_int));
        end
        @(posedge clk);
        host_req <= 1'b0;
        while (host_ack) begin
            @(negedge clk);
        end
        if (host_rdata != 16'd0) begin
            report_mismatch($sformatf("rdata %h after ack dropped", host_rdata));
        end
    endtask

    // ========================================
    // Stimulus
    // ========================================

    initial begin
        int          r;
        logic [15:0] wdata;
        logic [2:0]  post;
        void'($urandom(32'hfc2));
        errors          = 0;
        commands        = 0;
        model_cw        = fpu_exc_pkg::cw_reset_value;
        model_lat       = '0;
        model_int       = 1'b0;
        reset           <= 1'b1;
        host_req        <= 1'b0;
        host_cmd        <= fpu_exc_pkg::cmd_op;
        host_op         <= fpu_exc_pkg::op_add;
        host_a          <= '0;
        host_b          <= '0;
        host_post_flags <= '0;
        host_wdata      <= '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        // Clean status out of reset
        send_command(fpu_exc_pkg::cmd_stsw, fpu_exc_pkg::op_add, 0, 0, 0, 0);
        // Denormal under the all-masked default, no interrupt
        send_command(fpu_exc_pkg::cmd_op, fpu_exc_pkg::op_mul, 32'h0000_0001,
                     32'h3f80_0000, 3'b000, 0);
        for (int i = 0; i < 20; i++) begin
            send_command(fpu_exc_pkg::cmd_op, random_op(), random_operand(),
                         random_operand(), 3'($urandom), 0);
        end
        send_command(fpu_exc_pkg::cmd_stsw, fpu_exc_pkg::op_add, 0, 0, 0, 0);
        // Unmask all, ES follows while int_request stays low
        send_command(fpu_exc_pkg::cmd_ldcw, fpu_exc_pkg::op_add, 0, 0, 0, 16'h0340);
        send_command(fpu_exc_pkg::cmd_stsw, fpu_exc_pkg::op_add, 0, 0, 0, 0);
        send_command(fpu_exc_pkg::cmd_clex, fpu_exc_pkg::op_add, 0, 0, 0, 0);
        send_command(fpu_exc_pkg::cmd_stsw, fpu_exc_pkg::op_add, 0, 0, 0, 0);

        // Random mix, ops and status reads dominate
        for (int i = 0; i < num_random; i++) begin
            r     = $urandom_range(0, 99);
            wdata = $urandom;
            post  = ($urandom_range(0, 3) == 0) ? 3'($urandom) : 3'b000;
            if ($urandom_range(0, 3) == 0) begin
                wdata[5:0] = 6'h3f;
            end
            if (r < 50) begin
                send_command(fpu_exc_pkg::cmd_op, random_op(), random_operand(),
                             random_operand(), post, 0);
            end else if (r < 65) begin
                send_command(fpu_exc_pkg::cmd_ldcw, fpu_exc_pkg::op_add, 0, 0, 0, wdata);
            end else if (r < 90) begin
                send_command(fpu_exc_pkg::cmd_stsw, fpu_exc_pkg::op_add, 0, 0, 0, 0);
            end else begin
                send_command(fpu_exc_pkg::cmd_clex, fpu_exc_pkg::op_add, 0, 0, 0, 0);
            end
        end

        $display("Commands: %0d, errors: %0d", commands, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Watchdog, bounded by the command count times the per-command limit
    initial begin
        repeat ((num_random + num_directed) * cycle_limit) @(posedge clk);
        $display("Timeout: the DUT stopped answering host commands");
        $display("Simulation failed");
        $finish;
    end

endmodule

/* list.f */
logic/fpu_exc_pkg.sv
logic/fpu_exception_handler.sv
logic/fpu_operand_check.sv
logic/fpu_host_port.sv
logic/fpu_control_status.sv
logic/fpu_exception_unit.sv
tb/tb_fpu_exception_unit.sv
